/* frameBuffer.f */
+incdir+.
frameBufferPkg.sv
ramPortIf.sv
dualPortRam.sv
fragmentPort.sv
apbRegs.sv
frameBufferCtrl.sv
frameSweep.sv
frameBuffer.sv
frameBufferTb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        = frameBufferTb
FILELIST   = frameBuffer.f
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = test passed

SOURCES = $(filter %.sv,$(shell cat $(FILELIST))) frameBuffer_cfg.svh

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* frameBufferTb.sv */
`timescale 1ns/10ps
`include "frameBuffer_cfg.svh"

module frameBufferTb;

    import frameBufferPkg::*;

    logic                             clk;
    logic                             reset;
    logic [`FB_APB_ADDR_WIDTH-1:0]    paddr;
    logic                             psel;
    logic                             penable;
    logic                             pwrite;
    logic [31:0]                      pwdata;
    logic [31:0]                      prdata;
    logic                             pready;
    logic                             pslverr;
    logic [`FB_INDEX_WIDTH-1:0]       fragIndexRead;
    logic [`FB_INDEX_WIDTH-1:0]       fragIndexWrite;
    logic [`FB_PIXEL_WIDTH-1:0]       fragIn;
    logic                             fragWriteEnable;
    logic [`FB_SUB_PIXELS-1:0]        fragMask;
    logic [`FB_PIXEL_WIDTH-1:0]       fragOut;
    logic                             streamValid;
    logic                             streamReady;
    logic                             streamLast;
    logic [`FB_STREAM_WIDTH-1:0]      streamData;

    // Expected frame contents with one entry per pixel
    logic [`FB_PIXEL_WIDTH-1:0] model [`FB_FRAME_PIXELS];
    logic [31:0]                randState;
    int                         beatCount;
    logic                       streamExpected;

    frameBuffer u_frameBuffer (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] nextRandom();
        randState = randState * 32'd1664525 + 32'd1013904223;
        return randState;
    endfunction

    // Beat content has the lower-index pixel in the low half
    function automatic logic [31:0] refBeat(input int addr);
        return {model[2*addr+1], model[2*addr]};
    endfunction

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected)
        begin
            stopWithFailure($sformatf("Fail %s: got 0x%h, expected 0x%h",
                                      name, got, expected));
        end
    endtask

    task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data,
                            output logic err);
        @(negedge clk);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #2;
        err = pslverr;
        checkValue("pready", 32'(pready), 32'h1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbRead(input logic [3:0] addr, output logic [31:0] data,
                           output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #2;
        data = prdata;
        err  = pslverr;
        checkValue("pready", 32'(pready), 32'h1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic pollIdle();
        logic [31:0] data;
        logic        err;
        int          tries;
        tries = 0;
        data  = '0;
        while (data[0] !== 1'b1)
        begin
            apbRead(regStatus, data, err);
            checkValue("pslverr", 32'(err), 32'h0);
            tries++;
            if (tries > 100)
            begin
                stopWithFailure("STATUS never went back to idle");
            end
        end
    endtask

    // Accepted command must leave STATUS showing busy
    task automatic startCommand(input logic [1:0] cmdBits);
        logic [31:0] data;
        logic        err;
        apbWrite(regCmd, {30'b0, cmdBits}, err);
        checkValue("pslverr", 32'(err), 32'h0);
        apbRead(regStatus, data, err);
        checkValue("STATUS", data, 32'h0);
    endtask

    // Random back-pressure until the monitor has seen the whole frame
    task automatic drainStream();
        logic [31:0] r;
        int          cycles;
        cycles = 0;
        while (beatCount < `FB_FRAME_BEATS)
        begin
            @(negedge clk);
            r = nextRandom();
            streamReady = r[17:16] != 2'b00;
            cycles++;
            if (cycles > 500)
            begin
                stopWithFailure("commit stream did not deliver all beats in time");
            end
        end
        @(negedge clk);
        streamReady = 1'b0;
    endtask

    task automatic runCommit();
        beatCount      = 0;
        streamExpected = 1'b1;
        startCommand(2'b01);
        drainStream();
        pollIdle();
        streamExpected = 1'b0;
    endtask

    task automatic writePixel(input logic [5:0] idx, input logic [15:0] data,
                              input logic [3:0] mask);
        @(negedge clk);
        fragIndexWrite  = idx;
        fragIn          = data;
        fragMask        = mask;
        fragWriteEnable = 1'b1;
        @(negedge clk);
        fragWriteEnable = 1'b0;
        for (int s = 0; s < `FB_SUB_PIXELS; s++)
        begin
            if (mask[s])
            begin
                model[idx][s*4 +: 4] = data[s*4 +: 4];
            end
        end
    endtask

    // One cycle in the RAM, one in the output register
    task automatic checkFrame();
        for (int i = 0; i < `FB_FRAME_PIXELS; i++)
        begin
            @(negedge clk);
            fragIndexRead = 6'(i);
            @(negedge clk);
            @(negedge clk);
            checkValue("fragOut", 32'(fragOut), 32'(model[i]));
        end
    endtask

    ////////////////////////////////////////
    // Stream monitor
    ////////////////////////////////////////

    initial
    begin
        forever
        begin
            @(negedge clk);
            #2;
            if (streamValid === 1'b1)
            begin
                if (!streamExpected || beatCount >= `FB_FRAME_BEATS)
                begin
                    stopWithFailure("stream put out a beat when none was expected");
                end
                if (streamReady === 1'b1)
                begin
                    checkValue("streamData", streamData, refBeat(beatCount));
                    checkValue("streamLast", 32'(streamLast),
                               32'(beatCount == `FB_FRAME_BEATS - 1));
                    beatCount++;
                end
            end
            else if (streamLast === 1'b1)
            begin
                stopWithFailure("streamLast went high without streamValid");
            end
        end
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial
    begin
        logic [31:0] data;
        logic [31:0] r;
        logic        err;
        logic [15:0] color;
        logic [15:0] newColor;

        reset           = 1'b1;
        paddr           = '0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        pwdata          = '0;
        fragIndexRead   = '0;
        fragIndexWrite  = '0;
        fragIn          = '0;
        fragWriteEnable = 1'b0;
        fragMask        = '0;
        streamReady     = 1'b0;
        randState       = 32'h85de;
        beatCount       = 0;
        streamExpected  = 1'b0;

        repeat (2) @(negedge clk);
        reset = 1'b0;

        // Quiet outputs and idle status after reset
        checkValue("streamValid", 32'(streamValid), 32'h0);
        checkValue("streamLast", 32'(streamLast), 32'h0);
        apbRead(regStatus, data, err);
        checkValue("pslverr", 32'(err), 32'h0);
        checkValue("STATUS", data, 32'h1);

        // Clear color read-back, then memset
        r     = nextRandom();
        color = r[31:16];
        apbWrite(regClearColor, 32'(color), err);
        checkValue("pslverr", 32'(err), 32'h0);
        apbRead(regClearColor, data, err);
        checkValue("CLEAR_COLOR", data, 32'(color));
        startCommand(2'b10);
        pollIdle();
        for (int i = 0; i < `FB_FRAME_PIXELS; i++)
        begin
            model[i] = color;
        end
        checkFrame();

        // Masked fragment writes
        for (int n = 0; n < 48; n++)
        begin
            r    = nextRandom();
            data = nextRandom();
            writePixel(r[21:16], data[31:16], r[27:24]);
        end
        checkFrame();

        runCommit();

        // Commit plus memset with the color changed again mid-command
        r        = nextRandom();
        newColor = r[31:16];
        apbWrite(regClearColor, 32'(newColor), err);
        checkValue("pslverr", 32'(err), 32'h0);
        beatCount      = 0;
        streamExpected = 1'b1;
        startCommand(2'b11);
        apbWrite(regClearColor, 32'(~newColor), err);
        checkValue("pslverr", 32'(err), 32'h0);
        drainStream();
        pollIdle();
        streamExpected = 1'b0;
        for (int i = 0; i < `FB_FRAME_PIXELS; i++)
        begin
            model[i] = newColor;
        end
        runCommit();

        // Rejected accesses while a commit is stalled
        beatCount      = 0;
        streamExpected = 1'b1;
        startCommand(2'b01);
        apbWrite(regCmd, 32'h2, err);
        checkValue("pslverr", 32'(err), 32'h1);
        apbRead(4'hc, data, err);
        checkValue("pslverr", 32'(err), 32'h1);
        apbWrite(4'hc, 32'h3, err);
        checkValue("pslverr", 32'(err), 32'h1);
        drainStream();
        pollIdle();
        streamExpected = 1'b0;
        checkFrame();

        $display("test passed");
        $finish;
    end

endmodule

/* frameBuffer.sv */
`timescale 1ns/10ps
`include "frameBuffer_cfg.svh"

module frameBuffer
(
    input  logic                            clk,
    input  logic                            reset,

    // Host register access
    input  logic [`FB_APB_ADDR_WIDTH-1:0]   paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [31:0]                     pwdata,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            pslverr,

    // Rasterizer pixel access
    input  logic [`FB_INDEX_WIDTH-1:0]      fragIndexRead,
    input  logic [`FB_INDEX_WIDTH-1:0]      fragIndexWrite,
    input  logic [`FB_PIXEL_WIDTH-1:0]      fragIn,
    input  logic                            fragWriteEnable,
    input  logic [`FB_SUB_PIXELS-1:0]       fragMask,
    output logic [`FB_PIXEL_WIDTH-1:0]      fragOut,

    // Frame stream out
    output logic                            streamValid,
    input  logic                            streamReady,
    output logic                            streamLast,
    output logic [`FB_STREAM_WIDTH-1:0]     streamData
);

    import frameBufferPkg::*;

    logic                         apply;
    fbCmd_t                       cmd;
    logic [`FB_PIXEL_WIDTH-1:0]   clearColor;
    logic                         busy;
    sweepMode_e                   sweepMode;
    logic [`FB_PIXEL_WIDTH-1:0]   sweepColor;
    logic                         sweepDone;

    ramPortIf fragBus();
    ramPortIf ramBus();

    apbRegs u_apbRegs
    (
        .clk        (clk),
        .reset      (reset),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .busy       (busy),
        .apply      (apply),
        .cmd        (cmd),
        .clearColor (clearColor)
    );

    frameBufferCtrl u_frameBufferCtrl
    (
        .clk        (clk),
        .reset      (reset),
        .apply      (apply),
        .cmd        (cmd),
        .clearColor (clearColor),
        .sweepDone  (sweepDone),
        .busy       (busy),
        .sweepMode  (sweepMode),
        .sweepColor (sweepColor)
    );

    fragmentPort u_fragmentPort
    (
        .clk             (clk),
        .reset           (reset),
        .fragIndexRead   (fragIndexRead),
        .fragIndexWrite  (fragIndexWrite),
        .fragIn          (fragIn),
        .fragWriteEnable (fragWriteEnable),
        .fragMask        (fragMask),
        .fragOut         (fragOut),
        .bus             (fragBus.client)
    );

    frameSweep u_frameSweep
    (
        .clk         (clk),
        .reset       (reset),
        .sweepMode   (sweepMode),
        .sweepColor  (sweepColor),
        .sweepDone   (sweepDone),
        .fragBus     (fragBus.memory),
        .ramBus      (ramBus.client),
        .streamValid (streamValid),
        .streamReady (streamReady),
        .streamLast  (streamLast),
        .streamData  (streamData)
    );

    dualPortRam u_dualPortRam
    (
        .clk     (clk),
        .memPort (ramBus.memory)
    );

endmodule

/* frameSweep.sv */
`timescale 1ns/10ps
`include "frameBuffer_cfg.svh"

module frameSweep
(
    input  logic                           clk,
    input  logic                           reset,
    input  frameBufferPkg::sweepMode_e     sweepMode,
    input  logic [`FB_PIXEL_WIDTH-1:0]     sweepColor,
    output logic                           sweepDone,
    ramPortIf.memory                       fragBus,
    ramPortIf.client                       ramBus,
    output logic                           streamValid,
    input  logic                           streamReady,
    output logic                           streamLast,
    output logic [`FB_STREAM_WIDTH-1:0]    streamData
);

    import frameBufferPkg::*;

    localparam int addrWidth = `FB_BEAT_ADDR_WIDTH;
    localparam logic [addrWidth-1:0] lastBeat = addrWidth'(`FB_FRAME_BEATS - 1);

    logic [addrWidth-1:0] beatAddr;
    logic [addrWidth-1:0] beatAddrNext;
    logic                 accept;

    assign accept       = streamValid && streamReady;
    assign beatAddrNext = beatAddr + 1'b1;

    ////////////////////////////////////////
    // Beat counter and stream flags
    ////////////////////////////////////////

    // The counter wraps to zero after the last beat, ready for the next mode
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            beatAddr    <= '0;
            streamValid <= 1'b0;
            streamLast  <= 1'b0;
        end
        else
        begin
            case (sweepMode)
                sweepCommit:
                begin
                    if (!streamValid)
                    begin
                        // Beat 0 was fetched this cycle
                        streamValid <= 1'b1;
                    end
                    else if (streamReady)
                    begin
                        beatAddr   <= beatAddrNext;
                        streamLast <= beatAddrNext == lastBeat;
                        if (streamLast)
                        begin
                            streamValid <= 1'b0;
                        end
                    end
                end
                sweepMemset:
                begin
                    beatAddr <= beatAddrNext;
                end
                default:
                begin
                    beatAddr    <= '0;
                    streamValid <= 1'b0;
                    streamLast  <= 1'b0;
                end
            endcase
        end
    end

    assign sweepDone = (sweepMode == sweepCommit && accept && streamLast)
                    || (sweepMode == sweepMemset && beatAddr == lastBeat);

    ////////////////////////////////////////
    // RAM port multiplexer
    ////////////////////////////////////////

    always_comb
    begin
        ramBus.write     = fragBus.write;
        ramBus.writeAddr = fragBus.writeAddr;
        ramBus.writeData = fragBus.writeData;
        ramBus.writeMask = fragBus.writeMask;
        ramBus.readAddr  = fragBus.readAddr;
        case (sweepMode)
            sweepCommit:
            begin
                ramBus.write     = 1'b0;
                ramBus.writeAddr = beatAddr;
                ramBus.writeData = {`FB_PIXELS_PER_BEAT{sweepColor}};
                ramBus.writeMask = '0;
                // Fetch ahead so the RAM output always holds the current beat
                ramBus.readAddr  = accept ? beatAddrNext : beatAddr;
            end
            sweepMemset:
            begin
                ramBus.write     = 1'b1;
                ramBus.writeAddr = beatAddr;
                ramBus.writeData = {`FB_PIXELS_PER_BEAT{sweepColor}};
                ramBus.writeMask = '1;
                ramBus.readAddr  = beatAddr;
            end
            default: ;
        endcase
    end

    assign fragBus.readData = ramBus.readData;
    assign streamData       = ramBus.readData;

    stallHolds: assert property (@(posedge clk) disable iff (reset)
        streamValid && !streamReady |=> streamValid && $stable(streamData));

endmodule

/* frameBufferCtrl.sv */
`timescale 1ns/10ps
`include "frameBuffer_cfg.svh"

module frameBufferCtrl
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          apply,
    input  frameBufferPkg::fbCmd_t        cmd,
    input  logic [`FB_PIXEL_WIDTH-1:0]    clearColor,
    input  logic                          sweepDone,
    output logic                          busy,
    output frameBufferPkg::sweepMode_e    sweepMode,
    output logic [`FB_PIXEL_WIDTH-1:0]    sweepColor
);

    import frameBufferPkg::*;

    fbState_e state;
    logic     memsetPending;

    ////////////////////////////////////////
    // Command sequencing
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state         <= fbIdle;
            memsetPending <= 1'b0;
        end
        else
        begin
            case (state)
                fbIdle:
                begin
                    if (apply)
                    begin
                        memsetPending <= cmd.memset;
                        // Commit goes first when both bits are set
                        state <= cmd.commit ? fbCommitInit : fbMemset;
                    end
                end
                fbCommitInit:
                begin
                    state <= fbCommit;
                end
                fbCommit:
                begin
                    if (sweepDone)
                    begin
                        state <= memsetPending ? fbMemset : fbIdle;
                    end
                end
                fbMemset:
                begin
                    if (sweepDone)
                    begin
                        state <= fbIdle;
                    end
                end
                default: state <= fbIdle;
            endcase
        end
    end

    // Color is frozen at apply time so later host writes don't leak in
    always_ff @(posedge clk)
    begin
        if (state == fbIdle && apply)
        begin
            sweepColor <= clearColor;
        end
    end

    // The init cycle already runs the sweep so the first read is prefetched
    always_comb
    begin
        case (state)
            fbCommitInit, fbCommit: sweepMode = sweepCommit;
            fbMemset:               sweepMode = sweepMemset;
            default:                sweepMode = sweepNone;
        endcase
    end

    assign busy = state != fbIdle;

    applyOnlyWhenIdle: assert property (@(posedge clk) disable iff (reset)
        apply |-> state == fbIdle);

endmodule

/* apbRegs.sv */
`timescale 1ns/10ps
`include "frameBuffer_cfg.svh"

module apbRegs
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic [`FB_APB_ADDR_WIDTH-1:0]   paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [31:0]                     pwdata,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            pslverr,
    input  logic                            busy,
    output logic                            apply,
    output frameBufferPkg::fbCmd_t          cmd,
    output logic [`FB_PIXEL_WIDTH-1:0]      clearColor
);

    import frameBufferPkg::*;

    logic access;
    logic addrHit;
    logic cmdWrite;

    assign access   = psel && penable;
    assign cmdWrite = access && pwrite && (paddr == regCmd);

    // No wait states
    assign pready = 1'b1;

    ////////////////////////////////////////
    // Read decode
    ////////////////////////////////////////

    always_comb
    begin
        addrHit = 1'b1;
        prdata  = '0;
        case (paddr)
            regCmd:        prdata = 32'(cmd);
            regClearColor: prdata = 32'(clearColor);
            regStatus:     prdata = {31'b0, !busy};
            default:       addrHit = 1'b0;
        endcase
    end

    // Error only during the access phase
    assign pslverr = access && (!addrHit || (cmdWrite && busy));

    ////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            apply      <= 1'b0;
            cmd        <= '0;
            clearColor <= '0;
        end
        else
        begin
            apply <= 1'b0;
            if (access && pwrite && !pslverr)
            begin
                case (paddr)
                    regCmd:
                    begin
                        cmd   <= fbCmd_t'(pwdata[1:0]);
                        // Empty command is accepted but starts nothing
                        apply <= pwdata[1:0] != 2'b00;
                    end
                    regClearColor: clearColor <= pwdata[`FB_PIXEL_WIDTH-1:0];
                    default: ;
                endcase
            end
        end
    end

    enableInSel: assert property (@(posedge clk) disable iff (reset)
        penable |-> psel);

endmodule

/* fragmentPort.sv */
`timescale 1ns/10ps
`include "frameBuffer_cfg.svh"

module fragmentPort
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`FB_INDEX_WIDTH-1:0]    fragIndexRead,
    input  logic [`FB_INDEX_WIDTH-1:0]    fragIndexWrite,
    input  logic [`FB_PIXEL_WIDTH-1:0]    fragIn,
    input  logic                          fragWriteEnable,
    input  logic [`FB_SUB_PIXELS-1:0]     fragMask,
    output logic [`FB_PIXEL_WIDTH-1:0]    fragOut,
    ramPortIf.client                      bus
);

    localparam int selWidth = $clog2(`FB_PIXELS_PER_BEAT);

    logic [selWidth-1:0]              writeSel;
    logic [selWidth-1:0]              readSelQ;
    logic [`FB_STROBES_PER_BEAT-1:0]  strobe;

    ////////////////////////////////////////
    // Write path
    ////////////////////////////////////////

    assign writeSel = fragIndexWrite[selWidth-1:0];

    // Only the pixel slot picked by the low index bits gets the mask
    always_comb
    begin
        for (int p = 0; p < `FB_PIXELS_PER_BEAT; p++)
        begin
            strobe[p*`FB_SUB_PIXELS +: `FB_SUB_PIXELS] =
                (writeSel == selWidth'(p)) ? fragMask : '0;
        end
    end

    // An all-zero mask changes nothing, so it never reaches the RAM
    assign bus.write     = fragWriteEnable && (fragMask != '0);
    assign bus.writeAddr = fragIndexWrite[`FB_INDEX_WIDTH-1:selWidth];
    assign bus.writeData = {`FB_PIXELS_PER_BEAT{fragIn}};
    assign bus.writeMask = strobe;

    ////////////////////////////////////////
    // Read path
    ////////////////////////////////////////

    assign bus.readAddr = fragIndexRead[`FB_INDEX_WIDTH-1:selWidth];

    // Slot select lines up with the RAM output one cycle later
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            readSelQ <= '0;
        end
        else
        begin
            readSelQ <= fragIndexRead[selWidth-1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        fragOut <= bus.readData[readSelQ*`FB_PIXEL_WIDTH +: `FB_PIXEL_WIDTH];
    end

endmodule

/* dualPortRam.sv */
`timescale 1ns/10ps
`include "frameBuffer_cfg.svh"

module dualPortRam
(
    input  logic     clk,
    ramPortIf.memory memPort
);

    localparam int strobeWidth = `FB_SUB_PIXEL_WIDTH;

    logic [`FB_STREAM_WIDTH-1:0] mem [`FB_FRAME_BEATS];

    // Each strobe covers one sub-pixel field of the word
    always_ff @(posedge clk)
    begin
        if (memPort.write)
        begin
            for (int s = 0; s < `FB_STROBES_PER_BEAT; s++)
            begin
                if (memPort.writeMask[s])
                begin
                    mem[memPort.writeAddr][s*strobeWidth +: strobeWidth] <=
                        memPort.writeData[s*strobeWidth +: strobeWidth];
                end
            end
        end
    end

    // Registered read returns the old word when the same address is written
    always_ff @(posedge clk)
    begin
        memPort.readData <= mem[memPort.readAddr];
    end

    // Both clients must only issue writes that touch something
    maskNotEmpty: assert property (@(posedge clk)
        memPort.write |-> memPort.writeMask != '0);

endmodule

/* ramPortIf.sv */
`timescale 1ns/10ps
`include "frameBuffer_cfg.svh"

interface ramPortIf;

    // Write side
    logic                              write;
    logic [`FB_BEAT_ADDR_WIDTH-1:0]    writeAddr;
    logic [`FB_STREAM_WIDTH-1:0]       writeData;
    logic [`FB_STROBES_PER_BEAT-1:0]   writeMask;

    // Read side with data one cycle after the address
    logic [`FB_BEAT_ADDR_WIDTH-1:0]    readAddr;
    logic [`FB_STREAM_WIDTH-1:0]       readData;

    modport client
    (
        output write,
        output writeAddr,
        output writeData,
        output writeMask,
        output readAddr,
        input  readData
    );

    modport memory
    (
        input  write,
        input  writeAddr,
        input  writeData,
        input  writeMask,
        input  readAddr,
        output readData
    );

endinterface

/* frameBufferPkg.sv */
`include "frameBuffer_cfg.svh"

package frameBufferPkg;

    // Command controller states
    typedef enum logic [1:0]
    {
        fbIdle,
        fbCommitInit,
        fbCommit,
        fbMemset
    } fbState_e;

    // Job handed to the sweep engine
    typedef enum logic [1:0]
    {
        sweepNone,
        sweepCommit,
        sweepMemset
    } sweepMode_e;

    // Host register offsets
    typedef enum logic [`FB_APB_ADDR_WIDTH-1:0]
    {
        regCmd        = 'h0,
        regClearColor = 'h4,
        regStatus     = 'h8
    } fbRegAddr_e;

    // Commit sits in bit 0, memset in bit 1
    typedef struct packed
    {
        logic memset;
        logic commit;
    } fbCmd_t;

endpackage

/* frameBuffer_cfg.svh */
`ifndef FRAME_BUFFER_CFG_SVH
`define FRAME_BUFFER_CFG_SVH

////////////////////////////////////////
// Frame geometry
////////////////////////////////////////

`define FB_FRAME_PIXELS       64
`define FB_SUB_PIXELS         4
`define FB_SUB_PIXEL_WIDTH    4
`define FB_PIXEL_WIDTH        16
`define FB_INDEX_WIDTH        6

////////////////////////////////////////
// Stream and RAM word layout
////////////////////////////////////////

`define FB_STREAM_WIDTH       32
`define FB_PIXELS_PER_BEAT    2
`define FB_FRAME_BEATS        32
`define FB_BEAT_ADDR_WIDTH    5
`define FB_STROBES_PER_BEAT   8

// Host register window
`define FB_APB_ADDR_WIDTH     4

`endif
